// ==== verilog.f ====
hw/rv_decode_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/id_stage.sv
hw/id_ex_reg.sv
hw/decode_top.sv
test/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  # design, package first
  - files:
      - hw/rv_decode_pkg.sv
      - hw/decoder.sv
      - hw/regfile.sv
      - hw/id_stage.sv
      - hw/id_ex_reg.sv
      - hw/decode_top.sv

  # testbench for decode_top
  - target: test
    files:
      - test/tb_decode_top.sv

// ==== test/tb_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import rv_decode_pkg::*; ();

	localparam int clk_period   = 40;
	localparam int reset_cycles = 10;
	localparam int seed         = 95015;
	localparam int max_rows     = 32;

	// what a row checks after its clock edge
	localparam logic [1:0] m_full   = 2'd0;
	localparam logic [1:0] m_hold   = 2'd1;
	localparam logic [1:0] m_bubble = 2'd2;

	// control bits in the order rd_mem, wr_mem, cond, uncond, csr, halt, illegal
	localparam logic [6:0] c_rd     = 7'b1000000;
	localparam logic [6:0] c_wr     = 7'b0100000;
	localparam logic [6:0] c_cond   = 7'b0010000;
	localparam logic [6:0] c_uncond = 7'b0001000;
	localparam logic [6:0] c_csr    = 7'b0000100;
	localparam logic [6:0] c_halt   = 7'b0000010;
	localparam logic [6:0] c_ill    = 7'b0000001;

	typedef struct packed {
		logic [31:0]     inst;
		logic            valid;
		logic            ret_valid;
		logic [4:0]      ret_idx;
		logic [31:0]     ret_value;
		logic            stall;
		logic            flush;
		logic [1:0]      mode;
		alu_opa_select_e opa;
		alu_opb_select_e opb;
		alu_func_e       alu_f;
		channel_e        chan;
		logic [4:0]      dest;
		logic [6:0]      ctrl;
		logic            exp_valid;
		logic [31:0]     imm;
	} row_t;

	logic        clock;
	logic        rst_n;
	logic        stall;
	logic        flush;
	if_id_t      if_id;
	rob_retire_t retire;
	id_packet_t  id_ex;

	row_t            rows [max_rows];
	string           names [max_rows];
	int              n_rows;
	bit              table_ready;
	logic [xlen-1:0] shadow [32];
	// expected contents of id_ex as last loaded
	row_t            held;
	logic [31:0]     held_pc;
	logic [31:0]     held_rs1;
	logic [31:0]     held_rs2;
	int              pass_cnt;
	int              fail_cnt;
	int              errors;

	decode_top dut (
		.clock  (clock),
		.rst_n  (rst_n),
		.stall  (stall),
		.flush  (flush),
		.if_id  (if_id),
		.retire (retire),
		.id_ex  (id_ex)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	//////////////////////////////
	// instruction encoders
	//////////////////////////////

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// store, branch and jal scatter the immediate as the isa lays it out
	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [6:0] ctrl_bits(input id_packet_t p);
		return {p.rd_mem, p.wr_mem, p.cond_branch, p.uncond_branch,
			p.csr_op, p.halt, p.illegal};
	endfunction

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic check_value(input string name, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == 0) begin
			pass_cnt++;
			$display("test %-18s passed", name);
		end else begin
			fail_cnt++;
			$display("test %-18s failed with %0d mismatches", name, errors);
		end
		errors = 0;
	endtask

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	task automatic add_row(input string name, input logic [31:0] inst, input logic valid,
		input alu_opa_select_e opa, input alu_opb_select_e opb, input alu_func_e alu_f,
		input channel_e chan, input logic [4:0] dest, input logic [6:0] ctrl,
		input logic exp_valid, input logic [31:0] imm);
		row_t r;
		r = '0;
		r.inst      = inst;
		r.valid     = valid;
		r.mode      = m_full;
		r.opa       = opa;
		r.opb       = opb;
		r.alu_f     = alu_f;
		r.chan      = chan;
		r.dest      = dest;
		r.ctrl      = ctrl;
		r.exp_valid = exp_valid;
		r.imm       = imm;
		rows[n_rows]  = r;
		names[n_rows] = name;
		n_rows++;
	endtask

	// these two patch the row added last
	task automatic set_retire(input logic [4:0] idx, input logic [31:0] value);
		rows[n_rows-1].ret_valid = 1'b1;
		rows[n_rows-1].ret_idx   = idx;
		rows[n_rows-1].ret_value = value;
	endtask

	task automatic set_flow(input logic st, input logic fl, input logic [1:0] mode);
		rows[n_rows-1].stall = st;
		rows[n_rows-1].flush = fl;
		rows[n_rows-1].mode  = mode;
	endtask

	task automatic build_table();
		logic [4:0] r1;
		logic [4:0] r2;
		// one instruction per class
		add_row("addi", i_word(12'hffb, 5'd3, 3'b000, 5'd10, 7'h13), 1'b1, opa_is_rs1,
			opb_is_i_imm, alu_add, alu, 5'd10, 7'd0, 1'b1, 32'hffff_fffb);
		add_row("sltiu", i_word(12'h7ff, 5'd4, 3'b011, 5'd11, 7'h13), 1'b1, opa_is_rs1,
			opb_is_i_imm, alu_sltu, alu, 5'd11, 7'd0, 1'b1, 32'h0000_07ff);
		add_row("srai", i_word(12'h405, 5'd5, 3'b101, 5'd12, 7'h13), 1'b1, opa_is_rs1,
			opb_is_i_imm, alu_sra, alu, 5'd12, 7'd0, 1'b1, 32'h0000_0405);
		add_row("sub", r_word(7'h20, 5'd7, 5'd6, 3'b000, 5'd13, 7'h33), 1'b1, opa_is_rs1,
			opb_is_rs2, alu_sub, alu, 5'd13, 7'd0, 1'b1, 32'h0);
		add_row("mulhu", r_word(7'h01, 5'd9, 5'd8, 3'b011, 5'd14, 7'h33), 1'b1, opa_is_rs1,
			opb_is_rs2, alu_mulhu, mult, 5'd14, 7'd0, 1'b1, 32'h0);
		add_row("lui", u_word(20'h80123, 5'd15, 7'h37), 1'b1, opa_is_zero,
			opb_is_u_imm, alu_add, alu, 5'd15, 7'd0, 1'b1, 32'h8012_3000);
		add_row("auipc", u_word(20'h00042, 5'd16, 7'h17), 1'b1, opa_is_pc,
			opb_is_u_imm, alu_add, alu, 5'd16, 7'd0, 1'b1, 32'h0004_2000);
		add_row("jal", j_word(21'h0ad34, 5'd1), 1'b1, opa_is_pc,
			opb_is_j_imm, alu_add, br, 5'd1, c_uncond, 1'b1, 32'h0000_ad34);
		add_row("jalr", i_word(12'h800, 5'd2, 3'b000, 5'd5, 7'h67), 1'b1, opa_is_rs1,
			opb_is_i_imm, alu_add, br, 5'd5, c_uncond, 1'b1, 32'hffff_f800);
		add_row("bne", b_word(13'h0804, 5'd4, 5'd3, 3'b001), 1'b1, opa_is_pc,
			opb_is_b_imm, alu_add, br, 5'd0, c_cond, 1'b1, 32'h0000_0804);
		add_row("lw", i_word(12'h010, 5'd8, 3'b010, 5'd20, 7'h03), 1'b1, opa_is_rs1,
			opb_is_i_imm, alu_add, ld, 5'd20, c_rd, 1'b1, 32'h0000_0010);
		add_row("sw", s_word(12'hfe4, 5'd21, 5'd8, 3'b010), 1'b1, opa_is_rs1,
			opb_is_s_imm, alu_add, st, 5'd0, c_wr, 1'b1, 32'hffff_ffe4);
		add_row("csrrs", i_word(12'h300, 5'd0, 3'b010, 5'd7, 7'h73), 1'b1, opa_is_rs1,
			opb_is_rs2, alu_add, alu, 5'd0, c_csr, 1'b1, 32'h0);
		add_row("wfi", 32'h1050_0073, 1'b1, opa_is_rs1,
			opb_is_rs2, alu_add, alu, 5'd0, c_halt, 1'b1, 32'h0);
		// opcode 7f is unused and decodes as illegal and not valid
		add_row("bad_opcode", 32'h0246_8aff, 1'b1, opa_is_rs1,
			opb_is_rs2, alu_add, alu, 5'd0, c_ill, 1'b0, 32'h0);
		add_row("valid_low", i_word(12'h123, 5'd1, 3'b000, 5'd2, 7'h13), 1'b0, opa_is_rs1,
			opb_is_rs2, alu_add, alu, 5'd0, 7'd0, 1'b0, 32'h0);
		// register file paths
		add_row("retire_bypass", r_word(7'h00, 5'd17, 5'd9, 3'b110, 5'd22, 7'h33), 1'b1,
			opa_is_rs1, opb_is_rs2, alu_or, alu, 5'd22, 7'd0, 1'b1, 32'h0);
		set_retire(5'd9, $urandom);
		add_row("x0_write", r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd23, 7'h33), 1'b1,
			opa_is_rs1, opb_is_rs2, alu_add, alu, 5'd23, 7'd0, 1'b1, 32'h0);
		set_retire(5'd0, $urandom | 32'h1);
		add_row("x0_read_back", r_word(7'h00, 5'd0, 5'd0, 3'b111, 5'd24, 7'h33), 1'b1,
			opa_is_rs1, opb_is_rs2, alu_and, alu, 5'd24, 7'd0, 1'b1, 32'h0);
		for (int k = 0; k < 4; k++) begin
			r1 = 5'($urandom % 31 + 1);
			r2 = 5'($urandom % 31 + 1);
			add_row($sformatf("rand_read_%0d", k), r_word(7'h00, r2, r1, 3'b000, 5'd26, 7'h33),
				1'b1, opa_is_rs1, opb_is_rs2, alu_add, alu, 5'd26, 7'd0, 1'b1, 32'h0);
		end
		// stall and flush
		add_row("pre_stall", r_word(7'h00, 5'd11, 5'd10, 3'b100, 5'd24, 7'h33), 1'b1,
			opa_is_rs1, opb_is_rs2, alu_xor, alu, 5'd24, 7'd0, 1'b1, 32'h0);
		add_row("stall_hold", i_word(12'h0f0, 5'd12, 3'b111, 5'd25, 7'h13), 1'b1,
			opa_is_rs1, opb_is_i_imm, alu_and, alu, 5'd25, 7'd0, 1'b1, 32'h0000_00f0);
		set_flow(1'b1, 1'b0, m_hold);
		add_row("stall_release", i_word(12'h0f0, 5'd12, 3'b111, 5'd25, 7'h13), 1'b1,
			opa_is_rs1, opb_is_i_imm, alu_and, alu, 5'd25, 7'd0, 1'b1, 32'h0000_00f0);
		add_row("flush_with_stall", i_word(12'h010, 5'd8, 3'b010, 5'd20, 7'h03), 1'b1,
			opa_is_rs1, opb_is_i_imm, alu_add, ld, 5'd20, c_rd, 1'b1, 32'h0000_0010);
		set_flow(1'b1, 1'b1, m_bubble);
		add_row("after_flush", s_word(12'hfe4, 5'd21, 5'd8, 3'b010), 1'b1, opa_is_rs1,
			opb_is_s_imm, alu_add, st, 5'd0, c_wr, 1'b1, 32'hffff_ffe4);
		add_row("flush_only", b_word(13'h0804, 5'd4, 5'd3, 3'b001), 1'b1, opa_is_pc,
			opb_is_b_imm, alu_add, br, 5'd0, c_cond, 1'b1, 32'h0000_0804);
		set_flow(1'b0, 1'b1, m_bubble);
	endtask

	//////////////////////////////
	// test phases
	//////////////////////////////

	// after reset every register reads zero, two of them per cycle
	task automatic read_zero_regs();
		for (int k = 0; k < 16; k++) begin
			if_id.inst  = r_word(7'h00, 5'(31 - k), 5'(k), 3'b000, 5'd1, 7'h33);
			if_id.valid = 1'b1;
			@(negedge clock);
			check_value("reset_regs_zero", $sformatf("x%0d", k), 32'h0, id_ex.rs1_value);
			check_value("reset_regs_zero", $sformatf("x%0d", 31 - k), 32'h0, id_ex.rs2_value);
		end
		finish_test("reset_regs_zero");
	endtask

	// random values go into x1..x31 and into the shadow copy
	task automatic load_registers();
		if_id.valid = 1'b0;
		for (int k = 1; k < 32; k++) begin
			retire.valid          = 1'b1;
			retire.dest_reg_idx   = 5'(k);
			retire.dest_reg_value = $urandom;
			shadow[k]             = retire.dest_reg_value;
			@(negedge clock);
		end
		retire.valid = 1'b0;
		$display("loaded x1..x31 through the retire port");
	endtask

	task automatic apply_row(input int i);
		row_t        r;
		string       name;
		logic [31:0] exp_pc;
		logic [31:0] exp_rs1;
		logic [31:0] exp_rs2;
		r      = rows[i];
		name   = names[i];
		exp_pc = 32'h0000_1000 + 32'(i * 4);
		if_id.inst            = r.inst;
		if_id.pc              = exp_pc;
		if_id.npc             = exp_pc + 32'd4;
		if_id.valid           = r.valid;
		retire.valid          = r.ret_valid;
		retire.dest_reg_idx   = r.ret_idx;
		retire.dest_reg_value = r.ret_value;
		stall                 = r.stall;
		flush                 = r.flush;
		// a same-cycle retire is visible to this row through the bypass
		if (r.ret_valid && (r.ret_idx != 5'd0)) shadow[r.ret_idx] = r.ret_value;
		exp_rs1 = shadow[r.inst[19:15]];
		exp_rs2 = shadow[r.inst[24:20]];
		@(negedge clock);
		case (r.mode)
			m_full: begin
				check_value(name, "inst", r.inst, id_ex.inst);
				check_value(name, "pc", exp_pc, id_ex.pc);
				check_value(name, "npc", exp_pc + 32'd4, id_ex.npc);
				check_value(name, "opa_select", 32'(r.opa), 32'(id_ex.opa_select));
				check_value(name, "opb_select", 32'(r.opb), 32'(id_ex.opb_select));
				check_value(name, "alu_func", 32'(r.alu_f), 32'(id_ex.alu_func));
				check_value(name, "channel", 32'(r.chan), 32'(id_ex.channel));
				check_value(name, "dest_reg_idx", 32'(r.dest), 32'(id_ex.dest_reg_idx));
				check_value(name, "controls", 32'(r.ctrl), 32'(ctrl_bits(id_ex)));
				check_value(name, "valid", 32'(r.exp_valid), 32'(id_ex.valid));
				check_value(name, "imm", r.imm, id_ex.imm);
				check_value(name, "rs1_value", exp_rs1, id_ex.rs1_value);
				check_value(name, "rs2_value", exp_rs2, id_ex.rs2_value);
				held     = r;
				held_pc  = exp_pc;
				held_rs1 = exp_rs1;
				held_rs2 = exp_rs2;
			end
			m_hold: begin
				check_value(name, "inst", held.inst, id_ex.inst);
				check_value(name, "pc", held_pc, id_ex.pc);
				check_value(name, "npc", held_pc + 32'd4, id_ex.npc);
				check_value(name, "imm", held.imm, id_ex.imm);
				check_value(name, "rs1_value", held_rs1, id_ex.rs1_value);
				check_value(name, "rs2_value", held_rs2, id_ex.rs2_value);
				check_value(name, "controls", 32'(held.ctrl), 32'(ctrl_bits(id_ex)));
				check_value(name, "valid", 32'(held.exp_valid), 32'(id_ex.valid));
			end
			default: begin
				check_value(name, "controls", 32'h0, 32'(ctrl_bits(id_ex)));
				check_value(name, "valid", 32'h0, 32'(id_ex.valid));
			end
		endcase
		finish_test(name);
	endtask

	//////////////////////////////
	// main sequence and watchdog
	//////////////////////////////

	initial begin
		rst_n       = 1'b0;
		stall       = 1'b0;
		flush       = 1'b0;
		if_id       = '0;
		retire      = '0;
		n_rows      = 0;
		table_ready = 1'b0;
		held        = '0;
		held_pc     = '0;
		held_rs1    = '0;
		held_rs2    = '0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		errors      = 0;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0;
		end
		void'($urandom(seed));
		build_table();
		table_ready = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		check_value("reset_state", "controls", 32'h0, 32'(ctrl_bits(id_ex)));
		check_value("reset_state", "valid", 32'h0, 32'(id_ex.valid));
		finish_test("reset_state");
		read_zero_regs();
		load_registers();
		for (int i = 0; i < n_rows; i++) begin
			apply_row(i);
		end
		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// four cycles per row plus reset covers setup and every row with margin
	initial begin
		wait (table_ready);
		repeat (n_rows * 4 + reset_cycles) @(posedge clock);
		$display("watchdog expired and the run did not reach its end in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top import rv_decode_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        stall,
	input  logic        flush,
	input  if_id_t      if_id,
	input  rob_retire_t retire,
	output id_packet_t  id_ex
);

	// combinational decode result, registered one cycle later
	id_packet_t id_packet;

	id_stage id_stage_0 (
		.clock             (clock),
		.rst_n             (rst_n),
		.rob_retire_packet (retire),
		.if_id_packet      (if_id),
		.id_packet         (id_packet)
	);

	id_ex_reg id_ex_reg_0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.id_packet (id_packet),
		.id_ex     (id_ex)
	);

endmodule

`default_nettype wire

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import rv_decode_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       stall,
	input  logic       flush,
	input  id_packet_t id_packet,
	output id_packet_t id_ex
);

	//////////////////////////////
	// id/ex pipeline register
	//////////////////////////////

	// reset and flush both leave a bubble, flush beats stall
	// data fields keep whatever they held, only the controls are cleared
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			id_ex.valid         <= 1'b0;
			id_ex.rd_mem        <= 1'b0;
			id_ex.wr_mem        <= 1'b0;
			id_ex.cond_branch   <= 1'b0;
			id_ex.uncond_branch <= 1'b0;
			id_ex.csr_op        <= 1'b0;
			id_ex.halt          <= 1'b0;
			id_ex.illegal       <= 1'b0;
		end else if (!stall) begin
			id_ex <= id_packet;
		end
		// stall alone holds the whole packet
	end

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv_decode_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  rob_retire_t rob_retire_packet,
	input  if_id_t      if_id_packet,
	output id_packet_t  id_packet
);

	inst_t           inst;
	alu_opa_select_e opa_select;
	alu_opb_select_e opb_select;
	dest_reg_sel_e   dest_reg;
	alu_func_e       alu_func;
	channel_e        ex_channel;
	logic            rd_mem;
	logic            wr_mem;
	logic            cond_branch;
	logic            uncond_branch;
	logic            csr_op;
	logic            halt;
	logic            illegal;
	logic            valid_inst;
	logic [xlen-1:0] rs1_value;
	logic [xlen-1:0] rs2_value;
	logic [xlen-1:0] imm;
	logic [4:0]      dest_idx;

	assign inst = if_id_packet.inst;

	decoder decoder_0 (
		.if_packet     (if_id_packet),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.dest_reg      (dest_reg),
		.alu_func      (alu_func),
		.ex_channel    (ex_channel),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.csr_op        (csr_op),
		.halt          (halt),
		.illegal       (illegal),
		.valid_inst    (valid_inst)
	);

	// source indices sit in the same bits for every format that has them
	regfile regf_0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.rda_idx (inst.r.rs1),
		.rdb_idx (inst.r.rs2),
		.rda_out (rs1_value),
		.rdb_out (rs2_value),
		.wr_en   (rob_retire_packet.valid),
		.wr_idx  (rob_retire_packet.dest_reg_idx),
		.wr_data (rob_retire_packet.dest_reg_value)
	);

	//////////////////////////////
	// immediate and destination
	//////////////////////////////

	// sign bit is always inst[31], u form fills the upper 20 bits
	always_comb begin
		case (opb_select)
			opb_is_i_imm: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			opb_is_s_imm: imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			opb_is_b_imm: imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
				inst.b.imm10_5, inst.b.imm4_1, 1'b0};
			opb_is_u_imm: imm = {inst.u.imm, 12'h000};
			opb_is_j_imm: imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
				inst.j.imm11, inst.j.imm10_1, 1'b0};
			default:      imm = '0;
		endcase
	end

	// no destination maps onto x0
	assign dest_idx = (dest_reg == dest_rd) ? inst.r.rd : zero_reg;

	always_comb begin
		id_packet.inst          = inst;
		id_packet.pc            = if_id_packet.pc;
		id_packet.npc           = if_id_packet.npc;
		id_packet.rs1_value     = rs1_value;
		id_packet.rs2_value     = rs2_value;
		id_packet.imm           = imm;
		id_packet.dest_reg_idx  = dest_idx;
		id_packet.opa_select    = opa_select;
		id_packet.opb_select    = opb_select;
		id_packet.alu_func      = alu_func;
		id_packet.channel       = ex_channel;
		id_packet.rd_mem        = rd_mem;
		id_packet.wr_mem        = wr_mem;
		id_packet.cond_branch   = cond_branch;
		id_packet.uncond_branch = uncond_branch;
		id_packet.csr_op        = csr_op;
		id_packet.halt          = halt;
		id_packet.illegal       = illegal;
		id_packet.valid         = valid_inst;
	end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_decode_pkg::*; (
	input  logic            clock,
	input  logic            rst_n,
	input  logic [4:0]      rda_idx,
	input  logic [4:0]      rdb_idx,
	output logic [xlen-1:0] rda_out,
	output logic [xlen-1:0] rdb_out,
	input  logic            wr_en,
	input  logic [4:0]      wr_idx,
	input  logic [xlen-1:0] wr_data
);

	// x0 has no storage
	logic [xlen-1:0] regs [31:1];
	logic            wr_live;

	// writes aimed at x0 are dropped
	assign wr_live = wr_en && (wr_idx != zero_reg);

	// zero for x0, then the retiring value, then the array
	function automatic logic [xlen-1:0] read_port(input logic [4:0] idx);
		if (idx == zero_reg) return '0;
		else if (wr_live && (idx == wr_idx)) return wr_data;
		else return regs[idx];
	endfunction

	always_comb begin
		rda_out = read_port(rda_idx);
		rdb_out = read_port(rdb_idx);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_decode_pkg::*; (
	input  if_id_t          if_packet,
	output alu_opa_select_e opa_select,
	output alu_opb_select_e opb_select,
	output dest_reg_sel_e   dest_reg,
	output alu_func_e       alu_func,
	output channel_e        ex_channel,
	output logic            rd_mem,
	output logic            wr_mem,
	output logic            cond_branch,
	output logic            uncond_branch,
	output logic            csr_op,
	output logic            halt,
	output logic            illegal,
	output logic            valid_inst
);

	inst_t inst;
	logic  valid_in;

	assign inst     = if_packet.inst;
	assign valid_in = if_packet.valid;

	// illegal words never count as valid
	assign valid_inst = valid_in & ~illegal;

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		// noop defaults, each legal case overrides what it needs
		opa_select    = opa_is_rs1;
		opb_select    = opb_is_rs2;
		alu_func      = alu_add;
		dest_reg      = dest_none;
		ex_channel    = alu;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;

		if (valid_in) begin
			case (inst.r.opcode)
				op_lui: begin
					dest_reg   = dest_rd;
					opa_select = opa_is_zero;
					opb_select = opb_is_u_imm;
				end
				op_auipc: begin
					dest_reg   = dest_rd;
					opa_select = opa_is_pc;
					opb_select = opb_is_u_imm;
				end
				op_jal: begin
					// link value in rd, target is pc + j_imm
					dest_reg      = dest_rd;
					opa_select    = opa_is_pc;
					opb_select    = opb_is_j_imm;
					uncond_branch = 1'b1;
					ex_channel    = br;
				end
				op_jalr: begin
					if (inst.i.funct3 == f3_jalr) begin
						dest_reg      = dest_rd;
						opb_select    = opb_is_i_imm;
						uncond_branch = 1'b1;
						ex_channel    = br;
					end else begin
						illegal = 1'b1;
					end
				end
				op_branch: begin
					// funct3 010 and 011 are holes in the branch space
					case (inst.b.funct3)
						f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: begin
							opa_select  = opa_is_pc;
							opb_select  = opb_is_b_imm;
							cond_branch = 1'b1;
							ex_channel  = br;
						end
						default: illegal = 1'b1;
					endcase
				end
				op_load: begin
					case (inst.i.funct3)
						f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u: begin
							dest_reg   = dest_rd;
							opb_select = opb_is_i_imm;
							rd_mem     = 1'b1;
							ex_channel = ld;
						end
						default: illegal = 1'b1;
					endcase
				end
				op_store: begin
					case (inst.s.funct3)
						f3_byte, f3_half, f3_word: begin
							opb_select = opb_is_s_imm;
							wr_mem     = 1'b1;
							ex_channel = st;
						end
						default: illegal = 1'b1;
					endcase
				end
				op_op_imm: begin
					// shifts keep funct7 in the upper immediate bits
					case (inst.i.funct3)
						f3_add_sub: alu_func = alu_add;
						f3_slt:     alu_func = alu_slt;
						f3_sltu:    alu_func = alu_sltu;
						f3_xor:     alu_func = alu_xor;
						f3_or:      alu_func = alu_or;
						f3_and:     alu_func = alu_and;
						f3_sll: begin
							if (inst.r.funct7 == f7_base) alu_func = alu_sll;
							else illegal = 1'b1;
						end
						f3_srl_sra: begin
							if (inst.r.funct7 == f7_base) alu_func = alu_srl;
							else if (inst.r.funct7 == f7_alt) alu_func = alu_sra;
							else illegal = 1'b1;
						end
					endcase
					if (!illegal) begin
						dest_reg   = dest_rd;
						opb_select = opb_is_i_imm;
					end
				end
				op_op: begin
					case (inst.r.funct7)
						f7_base: begin
							case (inst.r.funct3)
								f3_add_sub: alu_func = alu_add;
								f3_sll:     alu_func = alu_sll;
								f3_slt:     alu_func = alu_slt;
								f3_sltu:    alu_func = alu_sltu;
								f3_xor:     alu_func = alu_xor;
								f3_srl_sra: alu_func = alu_srl;
								f3_or:      alu_func = alu_or;
								f3_and:     alu_func = alu_and;
							endcase
						end
						f7_alt: begin
							case (inst.r.funct3)
								f3_add_sub: alu_func = alu_sub;
								f3_srl_sra: alu_func = alu_sra;
								default:    illegal  = 1'b1;
							endcase
						end
						f7_muldiv: begin
							// divide and remainder are not implemented
							case (inst.r.funct3)
								f3_mul:    alu_func = alu_mul;
								f3_mulh:   alu_func = alu_mulh;
								f3_mulhsu: alu_func = alu_mulhsu;
								f3_mulhu:  alu_func = alu_mulhu;
								default:   illegal  = 1'b1;
							endcase
							if (!illegal) ex_channel = mult;
						end
						default: illegal = 1'b1;
					endcase
					if (!illegal) dest_reg = dest_rd;
				end
				op_system: begin
					// wfi stops the machine, csr ops only flag csr_op
					if (inst == wfi_word) begin
						halt = 1'b1;
					end else begin
						case (inst.i.funct3)
							f3_csrrw, f3_csrrs, f3_csrrc: csr_op = 1'b1;
							default: illegal = 1'b1;
						endcase
					end
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

	//////////////////////////////
	// widths and fixed indices
	//////////////////////////////

	// data word width, fixed by rv32
	localparam int xlen = 32;

	// x0 reads as zero, also used as "no destination"
	localparam logic [4:0] zero_reg = 5'd0;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// major opcodes, bits [6:0]
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// funct3 for op and op-imm
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct3 for the m extension, only the multiplies are supported
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_mulhu  = 3'b011;

	// branch conditions
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// load and store access widths
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// jalr only defines funct3 zero
	localparam logic [2:0] f3_jalr = 3'b000;

	// register forms of the csr group
	localparam logic [2:0] f3_csrrw = 3'b001;
	localparam logic [2:0] f3_csrrs = 3'b010;
	localparam logic [2:0] f3_csrrc = 3'b011;

	// funct7 selects base, alternate (sub/sra) or muldiv
	localparam logic [6:0] f7_base   = 7'b0000000;
	localparam logic [6:0] f7_alt    = 7'b0100000;
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	// wfi, treated as halt
	localparam logic [31:0] wfi_word = 32'h1050_0073;

	//////////////////////////////
	// instruction word views
	//////////////////////////////

	// one 32-bit word, read through whichever format the opcode implies
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

	//////////////////////////////
	// datapath selects
	//////////////////////////////

	typedef enum logic [1:0] {
		opa_is_rs1  = 2'h0,
		opa_is_pc   = 2'h1,
		opa_is_zero = 2'h2
	} alu_opa_select_e;

	typedef enum logic [2:0] {
		opb_is_rs2   = 3'h0,
		opb_is_i_imm = 3'h1,
		opb_is_s_imm = 3'h2,
		opb_is_b_imm = 3'h3,
		opb_is_u_imm = 3'h4,
		opb_is_j_imm = 3'h5
	} alu_opb_select_e;

	typedef enum logic {
		dest_none = 1'b0,
		dest_rd   = 1'b1
	} dest_reg_sel_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra,
		alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} alu_func_e;

	// which execution channel picks the instruction up
	typedef enum logic [2:0] {
		alu, br, ld, st, mult
	} channel_e;

	//////////////////////////////
	// stage packets
	//////////////////////////////

	typedef struct packed {
		inst_t           inst;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic            valid;
	} if_id_t;

	// architectural write from the retiring rob head
	typedef struct packed {
		logic            valid;
		logic [4:0]      dest_reg_idx;
		logic [xlen-1:0] dest_reg_value;
	} rob_retire_t;

	typedef struct packed {
		inst_t           inst;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
		logic [xlen-1:0] imm;
		logic [4:0]      dest_reg_idx;
		alu_opa_select_e opa_select;
		alu_opb_select_e opb_select;
		alu_func_e       alu_func;
		channel_e        channel;
		logic            rd_mem;
		logic            wr_mem;
		logic            cond_branch;
		logic            uncond_branch;
		logic            csr_op;
		logic            halt;
		logic            illegal;
		logic            valid;
	} id_packet_t;

endpackage

`default_nettype wire
